//--- rtl/mem_defines.svh
// Widths and timing of the memory stage.
// Misaligned accesses are not supported; the RAM uses only the low word-address bits.
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// ==============================
// datapath
// ==============================
`define MEM_XLEN        32
`define MEM_STRB_W      (`MEM_XLEN / 8)

// ==============================
// data ram
// ==============================
`define MEM_RAM_WORDS   256

// wait states seen by the requester, counted after SETUP
`define MEM_WAIT_W      4
`define MEM_RD_WAIT     2
`define MEM_WR_WAIT     1

`endif

//--- rtl/mem_pkg.sv
// Types shared by the memory stage blocks.
`default_nettype none

package mem_pkg;

    typedef enum logic [3:0] {
        LSU_NONE,
        LSU_LB,
        LSU_LH,
        LSU_LW,
        LSU_LBU,
        LSU_LHU,
        LSU_SB,
        LSU_SH,
        LSU_SW
    } lsu_op_e;

    typedef enum logic [1:0] {
        APB_IDLE,
        APB_SETUP,
        APB_ACCESS
    } apb_state_e;

    function automatic logic lsu_is_load(input lsu_op_e op);
        return op inside {LSU_LB, LSU_LH, LSU_LW, LSU_LBU, LSU_LHU};
    endfunction

    function automatic logic lsu_is_store(input lsu_op_e op);
        return op inside {LSU_SB, LSU_SH, LSU_SW};
    endfunction

    function automatic logic lsu_is_mem(input lsu_op_e op);
        return lsu_is_load(op) || lsu_is_store(op);
    endfunction

endpackage

`default_nettype wire

//--- rtl/mem_wait_timer.sv
// Countdown timer; a start overrides any count in progress.
`timescale 1ns/1ps
`default_nettype none

module mem_wait_timer #(
    parameter int WIDTH = 4
) (
    input  wire              clk,
    input  wire              reset,
    input  wire              start,
    input  wire [WIDTH-1:0]  load_value,
    output logic             expired
);

    logic [WIDTH-1:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (start) begin
            count <= load_value;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // holds at zero until the next start
    assign expired = (count == '0) && !start;

endmodule

`default_nettype wire

//--- rtl/mem_lsu_align.sv
// Byte-lane steering between the stage and the 32-bit data bus.
// Assumes naturally aligned accesses.
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module mem_lsu_align import mem_pkg::*; (
    input  wire lsu_op_e               lsu_op,
    input  wire [1:0]                  addr_low,
    input  wire [`MEM_XLEN-1:0]        rs2_data,
    input  wire [`MEM_XLEN-1:0]        bus_rdata,
    output logic [`MEM_XLEN-1:0]       store_data,
    output logic [`MEM_STRB_W-1:0]     store_strb,
    output logic [`MEM_XLEN-1:0]       load_data
);

    logic [`MEM_XLEN-1:0] shifted;

    // ==============================
    // store side
    // ==============================
    always_comb begin
        store_data = rs2_data;
        store_strb = '0;
        case (lsu_op)
            LSU_SB: begin
                store_data = {4{rs2_data[7:0]}};
                store_strb = 4'b0001 << addr_low;
            end
            LSU_SH: begin
                store_data = {2{rs2_data[15:0]}};
                store_strb = addr_low[1] ? 4'b1100 : 4'b0011;
            end
            LSU_SW: begin
                store_strb = 4'b1111;
            end
            default: begin
                store_strb = '0;
            end
        endcase
    end

    // ==============================
    // load side
    // ==============================
    assign shifted = bus_rdata >> {addr_low, 3'b000};

    always_comb begin
        case (lsu_op)
            LSU_LB:  load_data = {{24{shifted[7]}}, shifted[7:0]};
            LSU_LH:  load_data = {{16{shifted[15]}}, shifted[15:0]};
            LSU_LW:  load_data = bus_rdata;
            LSU_LBU: load_data = {24'd0, shifted[7:0]};
            LSU_LHU: load_data = {16'd0, shifted[15:0]};
            default: load_data = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/mem_apb_master.sv
// APB requester for the memory stage, one transfer per stage memory op.
// The stage inputs must stay stable while busy is high.
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module mem_apb_master import mem_pkg::*; (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        mem_valid,
    input  wire lsu_op_e               lsu_op,
    input  wire [`MEM_XLEN-1:0]        alu_out,
    input  wire [`MEM_XLEN-1:0]        store_data,
    input  wire [`MEM_STRB_W-1:0]      store_strb,
    input  wire [`MEM_XLEN-1:0]        prdata,
    input  wire                        pready,
    output logic                       psel,
    output logic                       penable,
    output logic                       pwrite,
    output logic [`MEM_XLEN-1:0]       paddr,
    output logic [`MEM_XLEN-1:0]       pwdata,
    output logic [`MEM_STRB_W-1:0]     pstrb,
    output logic [`MEM_XLEN-1:0]       rdata,
    output logic                       access_done,
    output logic                       busy
);

    apb_state_e state;
    apb_state_e state_next;
    logic       req;

    assign req = mem_valid && lsu_is_mem(lsu_op);

    // ==============================
    // state machine
    // ==============================
    always_comb begin
        state_next = state;
        case (state)
            APB_IDLE:   if (req) state_next = APB_SETUP;
            APB_SETUP:  state_next = APB_ACCESS;
            APB_ACCESS: if (pready) state_next = APB_IDLE;
            default:    state_next = APB_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= APB_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // request captured on the way into SETUP, held through ACCESS
    always_ff @(posedge clk) begin
        if (state == APB_IDLE && req) begin
            paddr  <= alu_out;
            pwdata <= store_data;
            pstrb  <= store_strb;
            pwrite <= lsu_is_store(lsu_op);
        end
    end

    assign psel    = (state != APB_IDLE);
    assign penable = (state == APB_ACCESS);

    assign access_done = (state == APB_ACCESS) && pready;
    assign rdata       = prdata;

    // high from the first cycle of the op up to, not including, completion
    assign busy = req && !access_done;

endmodule

`default_nettype wire

//--- rtl/mem_data_ram.sv
// APB completer RAM; wait states per direction come from the defines.
// Contents are undefined after reset. pslverr is not implemented.
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module mem_data_ram (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        psel,
    input  wire                        penable,
    input  wire                        pwrite,
    input  wire [`MEM_XLEN-1:0]        paddr,
    input  wire [`MEM_XLEN-1:0]        pwdata,
    input  wire [`MEM_STRB_W-1:0]      pstrb,
    output logic [`MEM_XLEN-1:0]       prdata,
    output logic                       pready
);

    localparam int IDX_W  = $clog2(`MEM_RAM_WORDS);
    localparam int WAIT_W = `MEM_WAIT_W;
    localparam logic [WAIT_W-1:0] RD_WAIT = `MEM_RD_WAIT;
    localparam logic [WAIT_W-1:0] WR_WAIT = `MEM_WR_WAIT;

    logic [`MEM_XLEN-1:0] mem [`MEM_RAM_WORDS];
    logic [IDX_W-1:0]     idx;
    logic                 timer_start;
    logic [WAIT_W-1:0]    timer_load;
    logic                 timer_expired;

    assign idx = paddr[IDX_W+1:2];

    // timer armed in SETUP so ACCESS sees the full count
    assign timer_start = psel && !penable;
    assign timer_load  = pwrite ? WR_WAIT : RD_WAIT;

    mem_wait_timer #(
        .WIDTH      (WAIT_W)
    ) mem_wait_timer_i (
        .clk        (clk),
        .reset      (reset),
        .start      (timer_start),
        .load_value (timer_load),
        .expired    (timer_expired)
    );

    assign pready = psel && penable && timer_expired;

    always_ff @(posedge clk) begin
        if (pready && pwrite) begin
            for (int b = 0; b < `MEM_STRB_W; b++) begin
                if (pstrb[b]) mem[idx][8*b +: 8] <= pwdata[8*b +: 8];
            end
        end
    end

    // read data valid on the completion cycle only
    assign prdata = (pready && !pwrite) ? mem[idx] : '0;

endmodule

`default_nettype wire

//--- rtl/mem_forward_unit.sv
// Operand bypass from MEM and WB, plus stall and flush for the pipeline.
// A load in MEM forwards only on its done cycle.
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module mem_forward_unit import mem_pkg::*; (
    input  wire                        if_valid,
    input  wire                        mem_valid,
    input  wire lsu_op_e               lsu_op,
    input  wire [4:0]                  rd,
    input  wire                        write_gpr,
    input  wire [`MEM_XLEN-1:0]        stage_result,
    input  wire                        access_done,
    input  wire                        busy,
    input  wire [4:0]                  id_rs1,
    input  wire [4:0]                  id_rs2,
    input  wire [4:0]                  ex_rs1,
    input  wire [4:0]                  ex_rs2,
    input  wire [4:0]                  wb_rd,
    input  wire                        wb_write_gpr,
    input  wire [`MEM_XLEN-1:0]        wb_data,
    output logic [`MEM_XLEN-1:0]       fwd_ex_rs1_data,
    output logic                       fwd_ex_rs1_hit,
    output logic [`MEM_XLEN-1:0]       fwd_ex_rs2_data,
    output logic                       fwd_ex_rs2_hit,
    output logic [`MEM_XLEN-1:0]       fwd_id_rs1_data,
    output logic                       fwd_id_rs1_hit,
    output logic [`MEM_XLEN-1:0]       fwd_id_rs2_data,
    output logic                       fwd_id_rs2_hit,
    output logic                       stall_if,
    output logic                       stall_id,
    output logic                       stall_ex,
    output logic                       stall_mem,
    output logic                       flush_wb
);

    logic [4:0]           rs_sel [4];
    logic [`MEM_XLEN-1:0] fwd_data [4];
    logic [3:0]           mem_hit;
    logic [3:0]           wb_hit;
    logic                 mem_ready;

    // 0 id_rs1, 1 id_rs2, 2 ex_rs1, 3 ex_rs2
    assign rs_sel[0] = id_rs1;
    assign rs_sel[1] = id_rs2;
    assign rs_sel[2] = ex_rs1;
    assign rs_sel[3] = ex_rs2;

    // load result exists only once the bus returns it
    assign mem_ready = mem_valid && write_gpr && (!lsu_is_load(lsu_op) || access_done);

    // ==============================
    // per-operand priority
    // ==============================
    for (genvar i = 0; i < 4; i++) begin : g_operand
        assign mem_hit[i] = (rs_sel[i] != 5'd0) && mem_ready && (rd == rs_sel[i]);
        assign wb_hit[i]  = (rs_sel[i] != 5'd0) && !mem_hit[i] && wb_write_gpr &&
                            (wb_rd == rs_sel[i]);
        assign fwd_data[i] = mem_hit[i] ? stage_result :
                             wb_hit[i]  ? wb_data : '0;
    end

    assign fwd_id_rs1_data = fwd_data[0];
    assign fwd_id_rs1_hit  = mem_hit[0] | wb_hit[0];
    assign fwd_id_rs2_data = fwd_data[1];
    assign fwd_id_rs2_hit  = mem_hit[1] | wb_hit[1];
    assign fwd_ex_rs1_data = fwd_data[2];
    assign fwd_ex_rs1_hit  = mem_hit[2] | wb_hit[2];
    assign fwd_ex_rs2_data = fwd_data[3];
    assign fwd_ex_rs2_hit  = mem_hit[3] | wb_hit[3];

    // ==============================
    // stall and flush
    // ==============================
    assign stall_if  = busy && if_valid;
    assign stall_id  = busy;
    assign stall_ex  = busy;
    assign stall_mem = busy;

    // write-back takes a bubble while MEM is held
    assign flush_wb = busy;

endmodule

`default_nettype wire

//--- rtl/mem_stage_top.sv
// Memory stage of the in-order pipeline with its internal APB data RAM.
// No write-back back-pressure; the result is valid for exactly one cycle.
// CSR forwarding and pc/instruction pass-through are not included.
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module mem_stage_top import mem_pkg::*; (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        if_valid,
    input  wire                        mem_valid,
    input  wire lsu_op_e               lsu_op,
    input  wire [`MEM_XLEN-1:0]        alu_out,
    input  wire [`MEM_XLEN-1:0]        rs2_data,
    input  wire [4:0]                  rd,
    input  wire                        write_gpr,
    input  wire                        mem_to_reg,
    input  wire [4:0]                  id_rs1,
    input  wire [4:0]                  id_rs2,
    input  wire [4:0]                  ex_rs1,
    input  wire [4:0]                  ex_rs2,
    input  wire [4:0]                  wb_rd,
    input  wire                        wb_write_gpr,
    input  wire [`MEM_XLEN-1:0]        wb_data,
    output logic                       out_valid,
    output logic [`MEM_XLEN-1:0]       out_result,
    output logic [4:0]                 out_rd,
    output logic                       out_write_gpr,
    output logic                       stall_if,
    output logic                       stall_id,
    output logic                       stall_ex,
    output logic                       stall_mem,
    output logic                       flush_wb,
    output logic [`MEM_XLEN-1:0]       fwd_ex_rs1_data,
    output logic                       fwd_ex_rs1_hit,
    output logic [`MEM_XLEN-1:0]       fwd_ex_rs2_data,
    output logic                       fwd_ex_rs2_hit,
    output logic [`MEM_XLEN-1:0]       fwd_id_rs1_data,
    output logic                       fwd_id_rs1_hit,
    output logic [`MEM_XLEN-1:0]       fwd_id_rs2_data,
    output logic                       fwd_id_rs2_hit
);

    // ==============================
    // internal APB bus
    // ==============================
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`MEM_XLEN-1:0]   paddr;
    logic [`MEM_XLEN-1:0]   pwdata;
    logic [`MEM_STRB_W-1:0] pstrb;
    logic [`MEM_XLEN-1:0]   prdata;
    logic                   pready;

    logic [`MEM_XLEN-1:0]   store_data;
    logic [`MEM_STRB_W-1:0] store_strb;
    logic [`MEM_XLEN-1:0]   rdata;
    logic [`MEM_XLEN-1:0]   load_data;
    logic [`MEM_XLEN-1:0]   stage_result;
    logic                   access_done;
    logic                   busy;

    mem_lsu_align mem_lsu_align_i (
        .lsu_op     (lsu_op),
        .addr_low   (alu_out[1:0]),
        .rs2_data   (rs2_data),
        .bus_rdata  (rdata),
        .store_data (store_data),
        .store_strb (store_strb),
        .load_data  (load_data)
    );

    mem_apb_master mem_apb_master_i (
        .clk         (clk),
        .reset       (reset),
        .mem_valid   (mem_valid),
        .lsu_op      (lsu_op),
        .alu_out     (alu_out),
        .store_data  (store_data),
        .store_strb  (store_strb),
        .prdata      (prdata),
        .pready      (pready),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .pstrb       (pstrb),
        .rdata       (rdata),
        .access_done (access_done),
        .busy        (busy)
    );

    mem_data_ram mem_data_ram_i (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .prdata  (prdata),
        .pready  (pready)
    );

    // load data for loads, otherwise the ALU result
    assign stage_result = mem_to_reg ? load_data : alu_out;

    // non-memory ops leave in the cycle they arrive
    assign out_valid     = mem_valid && (!lsu_is_mem(lsu_op) || access_done);
    assign out_result    = stage_result;
    assign out_rd        = rd;
    assign out_write_gpr = write_gpr && out_valid;

    mem_forward_unit mem_forward_unit_i (
        .if_valid        (if_valid),
        .mem_valid       (mem_valid),
        .lsu_op          (lsu_op),
        .rd              (rd),
        .write_gpr       (write_gpr),
        .stage_result    (stage_result),
        .access_done     (access_done),
        .busy            (busy),
        .id_rs1          (id_rs1),
        .id_rs2          (id_rs2),
        .ex_rs1          (ex_rs1),
        .ex_rs2          (ex_rs2),
        .wb_rd           (wb_rd),
        .wb_write_gpr    (wb_write_gpr),
        .wb_data         (wb_data),
        .fwd_ex_rs1_data (fwd_ex_rs1_data),
        .fwd_ex_rs1_hit  (fwd_ex_rs1_hit),
        .fwd_ex_rs2_data (fwd_ex_rs2_data),
        .fwd_ex_rs2_hit  (fwd_ex_rs2_hit),
        .fwd_id_rs1_data (fwd_id_rs1_data),
        .fwd_id_rs1_hit  (fwd_id_rs1_hit),
        .fwd_id_rs2_data (fwd_id_rs2_data),
        .fwd_id_rs2_hit  (fwd_id_rs2_hit),
        .stall_if        (stall_if),
        .stall_id        (stall_id),
        .stall_ex        (stall_ex),
        .stall_mem       (stall_mem),
        .flush_wb        (flush_wb)
    );

endmodule

`default_nettype wire

//--- sim/mem_stage_sva.sv
// APB protocol and stall checks for the memory stage, bound into the top level.
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module mem_stage_sva (
    input wire                        clk,
    input wire                        reset,
    input wire                        psel,
    input wire                        penable,
    input wire                        pwrite,
    input wire [`MEM_XLEN-1:0]        paddr,
    input wire [`MEM_XLEN-1:0]        pwdata,
    input wire [`MEM_STRB_W-1:0]      pstrb,
    input wire                        pready,
    input wire                        out_valid,
    input wire                        stall_mem
);

    int unsigned assert_fails = 0;

    // ACCESS always follows a SETUP cycle
    a_penable_after_setup: assert property (@(posedge clk) disable iff (reset)
        $rose(penable) |-> $past(psel && !penable))
        else begin
            $error("penable rose without a SETUP cycle");
            assert_fails++;
        end

    a_hold_until_ready: assert property (@(posedge clk) disable iff (reset)
        (psel && !pready) |=> (psel && $stable(paddr) && $stable(pwrite) &&
                               $stable(pwdata) && $stable(pstrb)))
        else begin
            $error("requester signals changed before pready");
            assert_fails++;
        end

    a_no_stall_on_valid: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> !stall_mem)
        else begin
            $error("stall_mem high while out_valid");
            assert_fails++;
        end

endmodule

bind mem_stage_top mem_stage_sva mem_stage_sva_i (
    .clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .pstrb(pstrb), .pready(pready),
    .out_valid(out_valid), .stall_mem(stall_mem)
);

`default_nettype wire

//--- sim/tb_mem_stage.sv
// Table-driven testbench for the memory stage.
// Addresses stay inside the first 1 KiB, and every byte is stored before it is loaded.
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module tb_mem_stage import mem_pkg::*; ();

    localparam int MAX_ROWS = 32;
    localparam int TIMEOUT  = 20;

    logic                 clk;
    logic                 reset;
    logic                 if_valid;
    logic                 mem_valid;
    lsu_op_e              lsu_op;
    logic [`MEM_XLEN-1:0] alu_out;
    logic [`MEM_XLEN-1:0] rs2_data;
    logic [4:0]           rd;
    logic                 write_gpr;
    logic                 mem_to_reg;
    logic [4:0]           rs [4];
    logic [4:0]           wb_rd;
    logic                 wb_write_gpr;
    logic [`MEM_XLEN-1:0] wb_data;
    logic                 out_valid;
    logic [`MEM_XLEN-1:0] out_result;
    logic [4:0]           out_rd;
    logic                 out_write_gpr;
    logic                 stall_if;
    logic                 stall_id;
    logic                 stall_ex;
    logic                 stall_mem;
    logic                 flush_wb;
    logic                 dut_hit [4];
    logic [`MEM_XLEN-1:0] dut_data [4];

    // operand order in the table is id_rs1 id_rs2 ex_rs1 ex_rs2
    lsu_op_e              t_op [MAX_ROWS];
    logic [`MEM_XLEN-1:0] t_addr [MAX_ROWS];
    logic [`MEM_XLEN-1:0] t_data [MAX_ROWS];
    logic [4:0]           t_rd [MAX_ROWS];
    logic                 t_wgpr [MAX_ROWS];
    logic [4:0]           t_rs [MAX_ROWS][4];
    logic [4:0]           t_wb_rd [MAX_ROWS];
    logic                 t_wb_w [MAX_ROWS];
    logic [`MEM_XLEN-1:0] t_wb_data [MAX_ROWS];
    logic [`MEM_XLEN-1:0] t_exp [MAX_ROWS];
    logic [1:0]           t_exp_hit [MAX_ROWS][4];
    int                   rows;
    int                   errors;

    logic [7:0] ref_mem [0:1023];

    mem_stage_top mem_stage_top_i (
        .clk(clk), .reset(reset), .if_valid(if_valid), .mem_valid(mem_valid),
        .lsu_op(lsu_op), .alu_out(alu_out), .rs2_data(rs2_data), .rd(rd),
        .write_gpr(write_gpr), .mem_to_reg(mem_to_reg),
        .id_rs1(rs[0]), .id_rs2(rs[1]), .ex_rs1(rs[2]), .ex_rs2(rs[3]),
        .wb_rd(wb_rd), .wb_write_gpr(wb_write_gpr), .wb_data(wb_data),
        .out_valid(out_valid), .out_result(out_result), .out_rd(out_rd),
        .out_write_gpr(out_write_gpr), .stall_if(stall_if), .stall_id(stall_id),
        .stall_ex(stall_ex), .stall_mem(stall_mem), .flush_wb(flush_wb),
        .fwd_id_rs1_data(dut_data[0]), .fwd_id_rs1_hit(dut_hit[0]),
        .fwd_id_rs2_data(dut_data[1]), .fwd_id_rs2_hit(dut_hit[1]),
        .fwd_ex_rs1_data(dut_data[2]), .fwd_ex_rs1_hit(dut_hit[2]),
        .fwd_ex_rs2_data(dut_data[3]), .fwd_ex_rs2_hit(dut_hit[3])
    );

    always #2 clk = ~clk;

    // 0 plain op, 1 load, 2 store
    function automatic int kind_of(input lsu_op_e op);
        case (op)
            LSU_LB, LSU_LH, LSU_LW, LSU_LBU, LSU_LHU: return 1;
            LSU_SB, LSU_SH, LSU_SW: return 2;
            default: return 0;
        endcase
    endfunction

    function automatic logic [31:0] ref_load(input lsu_op_e op, input logic [31:0] a);
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        logic [7:0] b3;
        b0 = ref_mem[a[9:0]];
        b1 = ref_mem[a[9:0] + 10'd1];
        b2 = ref_mem[a[9:0] + 10'd2];
        b3 = ref_mem[a[9:0] + 10'd3];
        case (op)
            LSU_LB:  return {{24{b0[7]}}, b0};
            LSU_LBU: return {24'd0, b0};
            LSU_LH:  return {{16{b1[7]}}, b1, b0};
            LSU_LHU: return {16'd0, b1, b0};
            LSU_LW:  return {b3, b2, b1, b0};
            default: return 32'd0;
        endcase
    endfunction

    task automatic ref_store(input lsu_op_e op, input logic [31:0] a, input logic [31:0] d);
        ref_mem[a[9:0]] = d[7:0];
        if (op != LSU_SB) ref_mem[a[9:0] + 10'd1] = d[15:8];
        if (op == LSU_SW) begin
            ref_mem[a[9:0] + 10'd2] = d[23:16];
            ref_mem[a[9:0] + 10'd3] = d[31:24];
        end
    endtask

    // 0 no hit, 1 MEM hit, 2 WB hit
    function automatic logic [1:0] hit_code(input logic [4:0] r, input int row, input bit done);
        if (r == 5'd0) return 2'd0;
        if (t_wgpr[row] && t_rd[row] == r && (kind_of(t_op[row]) != 1 || done)) return 2'd1;
        if (t_wb_w[row] && t_wb_rd[row] == r) return 2'd2;
        return 2'd0;
    endfunction

    task automatic add_row(input lsu_op_e op, input logic [31:0] addr, input logic [4:0] rd_i,
                           input logic [4:0] ex1, input logic [4:0] ex2, input logic [4:0] wbr,
                           input logic wbw);
        t_op[rows]      = op;
        t_addr[rows]    = addr;
        t_data[rows]    = $urandom;
        t_rd[rows]      = rd_i;
        t_wgpr[rows]    = (kind_of(op) != 2);
        t_rs[rows][0]   = 5'($urandom);
        t_rs[rows][1]   = ex1;
        t_rs[rows][2]   = ex1;
        t_rs[rows][3]   = ex2;
        t_wb_rd[rows]   = wbr;
        t_wb_w[rows]    = wbw;
        t_wb_data[rows] = $urandom;
        if (kind_of(op) == 2) ref_store(op, addr, t_data[rows]);
        t_exp[rows] = (kind_of(op) == 1) ? ref_load(op, addr) : addr;
        for (int k = 0; k < 4; k++) t_exp_hit[rows][k] = hit_code(t_rs[rows][k], rows, 1'b1);
        rows++;
    endtask

    task automatic check_operands(input int row, input bit done);
        logic [1:0] exp_code;
        for (int k = 0; k < 4; k++) begin
            exp_code = done ? t_exp_hit[row][k] : hit_code(t_rs[row][k], row, 1'b0);
            assert (dut_hit[k] == (exp_code != 2'd0)) else begin
                errors++;
                $display("[ERROR] %0t row %0d operand %0d hit %0b, expected code %0d",
                         $time, row, k, dut_hit[k], exp_code);
            end
            if (exp_code != 2'd0) begin
                assert (dut_data[k] == ((exp_code == 2'd1) ? t_exp[row] : t_wb_data[row]))
                else begin
                    errors++;
                    $display("[ERROR] %0t row %0d operand %0d data %h", $time, row, k,
                             dut_data[k]);
                end
            end
        end
    endtask

    task automatic check_quiet(input logic exp_stall);
        assert (stall_mem == exp_stall && stall_id == exp_stall && stall_ex == exp_stall &&
                stall_if == (exp_stall && if_valid) && flush_wb == exp_stall)
        else begin
            errors++;
            $display("[ERROR] %0t stall/flush mismatch, expected %0b", $time, exp_stall);
        end
    endtask

    task automatic run_row(input int row);
        int cyc;
        int exp_cyc;
        @(negedge clk);
        mem_valid    = 1'b1;
        if_valid     = (row % 2 == 0);
        lsu_op       = t_op[row];
        alu_out      = t_addr[row];
        rs2_data     = t_data[row];
        rd           = t_rd[row];
        write_gpr    = t_wgpr[row];
        mem_to_reg   = (kind_of(t_op[row]) == 1);
        for (int k = 0; k < 4; k++) rs[k] = t_rs[row][k];
        wb_rd        = t_wb_rd[row];
        wb_write_gpr = t_wb_w[row];
        wb_data      = t_wb_data[row];
        exp_cyc = (kind_of(t_op[row]) == 1) ? 2 + `MEM_RD_WAIT :
                  (kind_of(t_op[row]) == 2) ? 2 + `MEM_WR_WAIT : 0;
        cyc = 0;
        #1;
        while (!out_valid) begin
            check_quiet(1'b1);
            check_operands(row, 1'b0);
            cyc++;
            if (cyc > TIMEOUT) begin
                $display("timeout: out_valid never rose for row %0d", row);
                $display("*** TEST FAILED ***");
                $finish;
            end
            @(negedge clk);
            #1;
        end
        check_quiet(1'b0);
        check_operands(row, 1'b1);
        assert (cyc == exp_cyc && out_result == t_exp[row] && out_rd == t_rd[row] &&
                out_write_gpr == t_wgpr[row])
        else begin
            errors++;
            $display("[ERROR] %0t row %0d result %h after %0d cycles, expected %h after %0d",
                     $time, row, out_result, cyc, t_exp[row], exp_cyc);
        end
    endtask

    initial begin
        void'($urandom(36036));
        clk = 1'b0;
        reset = 1'b1;
        if_valid = 1'b1;
        mem_valid = 1'b0;
        lsu_op = LSU_NONE;
        alu_out = '0;
        rs2_data = '0;
        rd = '0;
        write_gpr = 1'b0;
        mem_to_reg = 1'b0;
        for (int k = 0; k < 4; k++) rs[k] = '0;
        wb_rd = '0;
        wb_write_gpr = 1'b0;
        wb_data = '0;
        errors = 0;
        rows = 0;

        // ==============================
        // stimulus table
        // ==============================
        add_row(LSU_SW, 32'h10, 5'd0, 5'd3, 5'd4, 5'($urandom), 1'b1);
        add_row(LSU_SW, 32'h14, 5'd0, 5'd0, 5'd0, 5'($urandom), 1'b0);
        add_row(LSU_SB, 32'h11, 5'd0, 5'd1, 5'd2, 5'd1, 1'b1);
        add_row(LSU_SB, 32'h16, 5'd0, 5'd0, 5'd0, 5'($urandom), 1'b1);
        add_row(LSU_SH, 32'h12, 5'd0, 5'd0, 5'd0, 5'd0, 1'b0);
        add_row(LSU_SB, 32'h10, 5'd0, 5'd0, 5'd0, 5'($urandom), 1'b1);
        add_row(LSU_SB, 32'h17, 5'd0, 5'd0, 5'd0, 5'd0, 1'b0);
        add_row(LSU_SH, 32'h14, 5'd0, 5'd0, 5'd0, 5'($urandom), 1'b1);
        add_row(LSU_LW, 32'h10, 5'd5, 5'd5, 5'd6, 5'd6, 1'b1);
        add_row(LSU_LB, 32'h11, 5'd6, 5'd6, 5'd0, 5'd6, 1'b1);
        add_row(LSU_LBU, 32'h11, 5'd7, 5'd1, 5'd7, 5'($urandom), 1'b1);
        add_row(LSU_LH, 32'h12, 5'd8, 5'd8, 5'd8, 5'd0, 1'b0);
        add_row(LSU_LHU, 32'h12, 5'd9, 5'd9, 5'd2, 5'd2, 1'b1);
        add_row(LSU_LB, 32'h16, 5'd10, 5'd0, 5'd0, 5'd0, 1'b0);
        add_row(LSU_LBU, 32'h14, 5'd11, 5'd11, 5'd0, 5'($urandom), 1'b1);
        add_row(LSU_LH, 32'h14, 5'd12, 5'd0, 5'd12, 5'd0, 1'b0);
        add_row(LSU_LHU, 32'h16, 5'd13, 5'd13, 5'd0, 5'd0, 1'b0);
        add_row(LSU_LB, 32'h13, 5'd14, 5'd0, 5'd0, 5'($urandom), 1'b1);
        add_row(LSU_NONE, $urandom, 5'd15, 5'd15, 5'd0, 5'd15, 1'b1);
        add_row(LSU_NONE, $urandom, 5'd16, 5'd17, 5'd16, 5'd17, 1'b1);
        add_row(LSU_NONE, $urandom, 5'd0, 5'd0, 5'd0, 5'd0, 1'b1);
        add_row(LSU_SW, 32'h3fc, 5'd0, 5'd0, 5'd0, 5'($urandom), 1'b1);
        add_row(LSU_LW, 32'h3fc, 5'd18, 5'd18, 5'd18, 5'd18, 1'b1);

        repeat (5) begin
            @(negedge clk);
            check_quiet(1'b0);
        end
        reset = 1'b0;
        repeat (3) begin
            @(negedge clk);
            #1;
            check_quiet(1'b0);
            assert (!out_valid) else begin
                errors++;
                $display("[ERROR] %0t out_valid high with no op", $time);
            end
        end

        for (int r = 0; r < rows; r++) run_row(r);
        @(negedge clk);
        mem_valid = 1'b0;
        repeat (2) @(negedge clk);

        $display("checked %0d rows, %0d errors, %0d assertion failures", rows, errors,
                 mem_stage_top_i.mem_stage_sva_i.assert_fails);
        if (errors == 0 && mem_stage_top_i.mem_stage_sva_i.assert_fails == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+rtl
rtl/mem_pkg.sv
rtl/mem_wait_timer.sv
rtl/mem_lsu_align.sv
rtl/mem_apb_master.sv
rtl/mem_data_ram.sv
rtl/mem_forward_unit.sv
rtl/mem_stage_top.sv
sim/mem_stage_sva.sv
sim/tb_mem_stage.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the memory stage testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_mem_stage -o Vtb_mem_stage

./obj_dir/Vtb_mem_stage > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
    exit 0
else
    echo "simulation did not pass"
    exit 1
fi
